// ==== project.f ====
+incdir+tb
src/rename_cfg_pkg.sv
src/micro_op_pkg.sv
src/rename_lane_if.sv
src/free_list.sv
src/map_table.sv
src/rename_lane.sv
src/rename_collect.sv
src/rat.sv
tb/rat_tb.sv

// ==== tb/rename_model.svh ====
/*
 * Reference rename model: speculative and committed maps and the
 * committed free-list queue with a speculative read position
 */
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

typedef micro_op_t [RENAME_WIDTH-1:0] uop_group_t;
typedef micro_op_t [COMMIT_WIDTH-1:0] retire_group_t;

prf_idx_t spec_map_m [ARF_INT_SIZE];
prf_idx_t com_map_m  [ARF_INT_SIZE];
// Free tags from the committed head to the tail, the first spec_pos already handed out
prf_idx_t fl_q [$];
int       spec_pos;

function automatic void reset_model();
  fl_q.delete();
  for (int a = 0; a < ARF_INT_SIZE; a++) begin
    spec_map_m[a] = prf_idx_t'(a);
    com_map_m[a]  = prf_idx_t'(a);
  end
  for (int t = ARF_INT_SIZE; t < PRF_INT_SIZE; t++) begin
    fl_q.push_back(prf_idx_t'(t));
  end
  spec_pos = 0;
endfunction

function automatic int free_tags();
  return fl_q.size() - spec_pos;
endfunction

// Renames a firing group in program order, so younger lanes see older writes
function automatic uop_group_t rename_group(input uop_group_t grp);
  prf_idx_t   smap [ARF_INT_SIZE];
  uop_group_t res;
  smap = spec_map_m;
  res  = '0;
  for (int i = 0; i < RENAME_WIDTH; i++) begin
    if (grp[i].valid) begin
      res[i]                             = grp[i];
      res[i].rs1_prf_int_index           = smap[grp[i].rs1_arf_int_index];
      res[i].rs2_prf_int_index           = smap[grp[i].rs2_arf_int_index];
      res[i].rd_valid                    = grp[i].rd_valid && grp[i].rd_arf_int_index != 0;
      res[i].rd_prf_int_index            = '0;
      res[i].rd_prf_int_index_prev       = '0;
      res[i].rd_prf_int_index_prev_valid = res[i].rd_valid;
      if (res[i].rd_valid) begin
        res[i].rd_prf_int_index      = fl_q[spec_pos];
        res[i].rd_prf_int_index_prev = smap[grp[i].rd_arf_int_index];
        smap[grp[i].rd_arf_int_index] = fl_q[spec_pos];
        spec_pos++;
      end
    end
  end
  spec_map_m = smap;
  return res;
endfunction

// The displaced tag joins the tail and the committed head moves past the used one
function automatic void retire_uop(input micro_op_t u);
  if (u.valid && u.rd_valid) begin
    com_map_m[u.rd_arf_int_index] = u.rd_prf_int_index;
    fl_q.push_back(u.rd_prf_int_index_prev);
    void'(fl_q.pop_front());
    spec_pos--;
  end
endfunction

function automatic void recover_model();
  spec_map_m = com_map_m;
  spec_pos   = 0;
endfunction

`endif

// ==== tb/rat_tb.sv ====
/*
 * Testbench for the rename stage: directed and random groups, in-order
 * retire feedback, recovery, output compare against the model and timeout
 */
`timescale 1ns/1ps
`default_nettype none

module rat_tb
  import rename_cfg_pkg::*, micro_op_pkg::*;
();

  localparam int CLK_PERIOD    = 40;
  localparam int RANDOM_CYCLES = 2400;
  // Roughly 2700 cycles of tests, with margin
  localparam int TIMEOUT_CYCLES = 4000;

  `include "rename_model.svh"

  logic          clock;
  logic          rst_n;
  logic          recover;
  uop_group_t    uop_in;
  retire_group_t uop_retire;
  uop_group_t    uop_out;
  logic          allocatable;

  uop_group_t exp_q [$];
  micro_op_t  inflight_q [$];
  logic       exp_alloc;
  bit         checking    = 1'b0;
  int         cycle_count = 0;
  string      test_name   = "reset";

  rat i_dut (
    .clock       (clock),
    .rst_n       (rst_n),
    .recover     (recover),
    .uop_in      (uop_in),
    .uop_retire  (uop_retire),
    .uop_out     (uop_out),
    .allocatable (allocatable)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Verification failed");
      $fatal(1, "timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    end
  end

  task automatic check_value(input string what, input logic [79:0] expected,
                             input logic [79:0] actual);
    if (expected !== actual) begin
      $display("error %s %s: expected %h, actual %h", test_name, what, expected, actual);
      $display("Verification failed");
      $fatal(1, "mismatch on %s", what);
    end
  endtask

  // uop_out in this cycle holds the group driven one cycle earlier
  always @(negedge clock) begin
    uop_group_t expected;
    if (checking) begin
      if (exp_q.size() == 0) begin
        $display("Verification failed");
        $fatal(1, "no expected group was queued for the output compare");
      end else begin
        expected = exp_q.pop_front();
        for (int i = 0; i < RENAME_WIDTH; i++) begin
          check_value($sformatf("uop_out lane %0d", i), expected[i], uop_out[i]);
        end
        check_value("allocatable", exp_alloc, allocatable);
      end
    end
  end

  function automatic bit coin(input int pct);
    return $urandom_range(99, 0) < pct;
  endfunction

  function automatic int random_reg();
    return coin(10) ? 0 : $urandom_range(ARF_INT_SIZE - 1, 1);
  endfunction

  // Physical fields start as junk since rename has to overwrite them
  function automatic micro_op_t make_uop(input bit valid, input int rs1, input int rs2,
                                         input int rd, input bit rd_valid);
    logic [95:0] junk;
    micro_op_t   u;
    junk                = {$urandom, $urandom, $urandom};
    u                   = junk[$bits(micro_op_t)-1:0];
    u.valid             = valid;
    u.rd_valid          = rd_valid;
    u.rs1_arf_int_index = arf_idx_t'(rs1);
    u.rs2_arf_int_index = arf_idx_t'(rs2);
    u.rd_arf_int_index  = arf_idx_t'(rd);
    return u;
  endfunction

  function automatic uop_group_t random_group();
    uop_group_t grp;
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      grp[i] = make_uop(coin(75), random_reg(), random_reg(), random_reg(), coin(75));
    end
    return grp;
  endfunction

  // Lane 1 often reads or writes the register that lane 0 writes
  function automatic uop_group_t bypass_group();
    uop_group_t grp;
    int         rd0;
    rd0    = random_reg();
    grp[0] = make_uop(coin(85), random_reg(), random_reg(), rd0, coin(85));
    grp[1] = make_uop(1'b1, coin(50) ? rd0 : random_reg(), coin(50) ? rd0 : random_reg(),
                      coin(50) ? rd0 : random_reg(), coin(85));
    return grp;
  endfunction

  task automatic run_cycle(input uop_group_t grp, input bit do_recover, input int max_retire);
    retire_group_t ret;
    uop_group_t    expected;
    int            n_ret;
    bit            any_valid;
    @(posedge clock);
    ret       = '0;
    expected  = '0;
    any_valid = 1'b0;
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      any_valid |= grp[i].valid;
    end
    exp_alloc = free_tags() >= RENAME_WIDTH;
    if (do_recover) begin
      recover_model();
      inflight_q.delete();
    end else begin
      if (any_valid && exp_alloc) begin
        expected = rename_group(grp);
      end
      n_ret = $urandom_range(max_retire, 0);
      for (int i = 0; i < n_ret && inflight_q.size() > 0; i++) begin
        ret[i] = inflight_q.pop_front();
        retire_uop(ret[i]);
      end
      for (int i = 0; i < RENAME_WIDTH; i++) begin
        if (expected[i].valid) begin
          inflight_q.push_back(expected[i]);
        end
      end
    end
    exp_q.push_back(expected);
    uop_in     <= grp;
    uop_retire <= ret;
    recover    <= do_recover;
  endtask

  initial begin
    uop_group_t grp;
    void'($urandom(80191));
    rst_n      = 1'b0;
    recover    = 1'b0;
    uop_in     = '0;
    uop_retire = '0;
    reset_model();
    exp_alloc = 1'b1;
    repeat (10) @(posedge clock);
    rst_n <= 1'b1;
    // Two idle groups cover the reset edge and the first edge after it
    exp_q.push_back('0);
    exp_q.push_back('0);
    checking = 1'b1;

    test_name = "identity_map";
    for (int i = 0; i < ARF_INT_SIZE / 2; i++) begin
      grp[0] = make_uop(1'b1, 2 * i, 2 * i + 1, 2 * i, 1'b1);
      grp[1] = make_uop(1'b1, 2 * i + 1, 0, 2 * i + 1, 1'b1);
      run_cycle(grp, 1'b0, 0);
    end
    test_name = "free_list_empty";
    repeat (4) run_cycle(random_group(), 1'b0, 0);
    test_name = "retire_reuse";
    repeat (30) run_cycle(random_group(), 1'b0, COMMIT_WIDTH);
    test_name = "same_group_bypass";
    repeat (60) run_cycle(bypass_group(), 1'b0, COMMIT_WIDTH);
    test_name = "recover";
    repeat (20) begin
      repeat ($urandom_range(10, 3)) run_cycle(random_group(), 1'b0, COMMIT_WIDTH);
      run_cycle(random_group(), 1'b1, 0);
    end
    test_name = "random_mix";
    for (int i = 0; i < RANDOM_CYCLES; i++) begin
      // Retirement stalls for 70 of every 300 cycles so the free list runs dry
      run_cycle(coin(50) ? bypass_group() : random_group(), coin(2),
                (i % 300) < 70 ? 0 : COMMIT_WIDTH);
    end
    test_name = "drain";
    repeat (3) run_cycle('0, 1'b0, 0);
    @(negedge clock);
    #1;
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/rat.sv ====
/*
 * Register rename stage top: free list, map table,
 * rename lanes and group collector
 */
`timescale 1ns/1ps
`default_nettype none

module rat
  import rename_cfg_pkg::*, micro_op_pkg::*;
(
  input  logic                         clock,
  input  logic                         rst_n,
  input  logic                         recover,
  input  micro_op_t [RENAME_WIDTH-1:0] uop_in,
  input  micro_op_t [COMMIT_WIDTH-1:0] uop_retire,
  output micro_op_t [RENAME_WIDTH-1:0] uop_out,
  output logic                         allocatable
);

  prf_idx_t [RENAME_WIDTH-1:0] head_tags;
  logic                        fire;
  logic     [1:0]              alloc_count;
  logic     [RENAME_WIDTH-1:0] older_writes;
  arf_idx_t [RENAME_WIDTH-1:0] older_rd;
  prf_idx_t [RENAME_WIDTH-1:0] older_prd;

  logic     [COMMIT_WIDTH-1:0] retire_free_valid;
  prf_idx_t [COMMIT_WIDTH-1:0] retire_free_tag;
  logic     [1:0]              retire_alloc_count;

  rename_lane_if lane_bus [RENAME_WIDTH] ();

  // Each retiring writer frees the tag it displaced
  always_comb begin
    retire_alloc_count = '0;
    for (int i = 0; i < COMMIT_WIDTH; i++) begin
      retire_free_valid[i] = uop_retire[i].valid & uop_retire[i].rd_prf_int_index_prev_valid;
      retire_free_tag[i]   = uop_retire[i].rd_prf_int_index_prev;
      retire_alloc_count   = retire_alloc_count +
                             {1'b0, uop_retire[i].valid & uop_retire[i].rd_valid};
    end
  end

  free_list u_free_list (
    .clock              (clock),
    .rst_n              (rst_n),
    .recover            (recover),
    .fire               (fire),
    .alloc_count        (alloc_count),
    .retire_free_valid  (retire_free_valid),
    .retire_free_tag    (retire_free_tag),
    .retire_alloc_count (retire_alloc_count),
    .head_tags          (head_tags),
    .allocatable        (allocatable)
  );

  map_table u_map_table (
    .clock      (clock),
    .rst_n      (rst_n),
    .recover    (recover),
    .fire       (fire),
    .uop_retire (uop_retire),
    .lanes      (lane_bus)
  );

  for (genvar g = 0; g < RENAME_WIDTH; g++) begin : g_lane
    assign lane_bus[g].uop = uop_in[g];

    rename_lane #(
      .LANE (g)
    ) u_lane (
      .uop_in       (lane_bus[g].uop),
      .head_tags    (head_tags),
      .older_writes (older_writes),
      .older_rd     (older_rd),
      .older_prd    (older_prd),
      .lane         (lane_bus[g])
    );
  end

  rename_collect u_collect (
    .clock        (clock),
    .rst_n        (rst_n),
    .recover      (recover),
    .allocatable  (allocatable),
    .lanes        (lane_bus),
    .fire         (fire),
    .alloc_count  (alloc_count),
    .uop_out      (uop_out),
    .older_writes (older_writes),
    .older_rd     (older_rd),
    .older_prd    (older_prd)
  );

endmodule

`default_nettype wire

// ==== src/rename_collect.sv ====
/*
 * Group collector: bypass vectors for the lanes, allocation count,
 * fire decision and the registered output group
 */
`timescale 1ns/1ps
`default_nettype none

module rename_collect
  import rename_cfg_pkg::*, micro_op_pkg::*;
(
  input  logic                         clock,
  input  logic                         rst_n,
  input  logic                         recover,
  input  logic                         allocatable,
  rename_lane_if.collect               lanes [RENAME_WIDTH],
  output logic                         fire,
  output logic      [1:0]              alloc_count,
  output micro_op_t [RENAME_WIDTH-1:0] uop_out,
  output logic      [RENAME_WIDTH-1:0] older_writes,
  output arf_idx_t  [RENAME_WIDTH-1:0] older_rd,
  output prf_idx_t  [RENAME_WIDTH-1:0] older_prd
);

  micro_op_t [RENAME_WIDTH-1:0] renamed;
  logic                         any_valid;

  for (genvar g = 0; g < RENAME_WIDTH; g++) begin : g_gather
    assign older_writes[g] = lanes[g].writes;
    assign older_rd[g]     = lanes[g].rd;
    assign older_prd[g]    = lanes[g].new_prd;
    assign renamed[g]      = lanes[g].uop_renamed;
  end

  always_comb begin
    alloc_count = '0;
    any_valid   = 1'b0;
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      alloc_count = alloc_count + {1'b0, older_writes[i]};
      any_valid   = any_valid | renamed[i].valid;
    end
  end

  // Whole group goes or none of it does
  assign fire = any_valid & allocatable & ~recover;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      uop_out <= '0;
    end else if (fire) begin
      uop_out <= renamed;
    end else begin
      uop_out <= '0;
    end
  end

endmodule

`default_nettype wire

// ==== src/rename_lane.sv ====
/*
 * One rename lane: operand extraction, tag pick from the free-list
 * head and bypass from older lanes of the same group
 */
`timescale 1ns/1ps
`default_nettype none

module rename_lane
  import rename_cfg_pkg::*, micro_op_pkg::*;
#(
  parameter int LANE = 0
) (
  input  micro_op_t                   uop_in,
  input  prf_idx_t [RENAME_WIDTH-1:0] head_tags,
  input  logic     [RENAME_WIDTH-1:0] older_writes,
  input  arf_idx_t [RENAME_WIDTH-1:0] older_rd,
  input  prf_idx_t [RENAME_WIDTH-1:0] older_prd,
  rename_lane_if.lane                 lane
);

  logic                              writes_int;
  logic [$clog2(RENAME_WIDTH+1)-1:0] alloc_ofs;
  prf_idx_t                          prs1_byp;
  prf_idx_t                          prs2_byp;
  prf_idx_t                          prev_byp;

  assign lane.rs1 = uop_in.valid ? uop_in.rs1_arf_int_index : '0;
  assign lane.rs2 = uop_in.valid ? uop_in.rs2_arf_int_index : '0;
  assign lane.rd  = uop_in.valid ? uop_in.rd_arf_int_index  : '0;

  // x0 is never renamed
  assign writes_int  = uop_in.valid & uop_in.rd_valid & (uop_in.rd_arf_int_index != '0);
  assign lane.writes = writes_int;

  // Older writers take the earlier tags; the youngest matching one is forwarded
  always_comb begin
    alloc_ofs = '0;
    prs1_byp  = lane.prs1;
    prs2_byp  = lane.prs2;
    prev_byp  = lane.prev_rd;
    for (int j = 0; j < LANE; j++) begin
      alloc_ofs = alloc_ofs + older_writes[j];
      if (older_writes[j] && older_rd[j] == lane.rs1) prs1_byp = older_prd[j];
      if (older_writes[j] && older_rd[j] == lane.rs2) prs2_byp = older_prd[j];
      if (older_writes[j] && older_rd[j] == lane.rd)  prev_byp = older_prd[j];
    end
  end

  assign lane.new_prd = head_tags[alloc_ofs];

  always_comb begin
    lane.uop_renamed = '0;
    if (uop_in.valid) begin
      lane.uop_renamed                             = uop_in;
      lane.uop_renamed.rd_valid                    = writes_int;
      lane.uop_renamed.rs1_prf_int_index           = prs1_byp;
      lane.uop_renamed.rs2_prf_int_index           = prs2_byp;
      lane.uop_renamed.rd_prf_int_index            = writes_int ? lane.new_prd : '0;
      lane.uop_renamed.rd_prf_int_index_prev       = writes_int ? prev_byp : '0;
      lane.uop_renamed.rd_prf_int_index_prev_valid = writes_int;
    end
  end

endmodule

`default_nettype wire

// ==== src/map_table.sv ====
/*
 * Speculative and committed architectural to physical maps,
 * per-lane lookups, group writes, retire updates and recovery
 */
`timescale 1ns/1ps
`default_nettype none

module map_table
  import rename_cfg_pkg::*, micro_op_pkg::*;
(
  input  logic                         clock,
  input  logic                         rst_n,
  input  logic                         recover,
  input  logic                         fire,
  input  micro_op_t [COMMIT_WIDTH-1:0] uop_retire,
  rename_lane_if.map                   lanes [RENAME_WIDTH]
);

  prf_idx_t spec_map [ARF_INT_SIZE];
  prf_idx_t com_map  [ARF_INT_SIZE];

  logic     [RENAME_WIDTH-1:0] wr_en;
  arf_idx_t [RENAME_WIDTH-1:0] wr_rd;
  prf_idx_t [RENAME_WIDTH-1:0] wr_tag;

  for (genvar g = 0; g < RENAME_WIDTH; g++) begin : g_port
    assign wr_en[g]  = lanes[g].writes;
    assign wr_rd[g]  = lanes[g].rd;
    assign wr_tag[g] = lanes[g].new_prd;

    // Lookups see the map as it stood before this group
    assign lanes[g].prs1    = spec_map[lanes[g].rs1];
    assign lanes[g].prs2    = spec_map[lanes[g].rs2];
    assign lanes[g].prev_rd = spec_map[lanes[g].rd];
  end

  // Lanes are written in order so the youngest writer of an rd wins
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int a = 0; a < ARF_INT_SIZE; a++) begin
        spec_map[a] <= prf_idx_t'(a);
      end
    end else if (recover) begin
      spec_map <= com_map;
    end else if (fire) begin
      for (int i = 0; i < RENAME_WIDTH; i++) begin
        if (wr_en[i]) begin
          spec_map[wr_rd[i]] <= wr_tag[i];
        end
      end
    end
  end

  // Retire slots are in program order, later slot wins on the same rd
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int a = 0; a < ARF_INT_SIZE; a++) begin
        com_map[a] <= prf_idx_t'(a);
      end
    end else begin
      for (int i = 0; i < COMMIT_WIDTH; i++) begin
        if (uop_retire[i].valid && uop_retire[i].rd_valid &&
            uop_retire[i].rd_arf_int_index != '0) begin
          com_map[uop_retire[i].rd_arf_int_index] <= uop_retire[i].rd_prf_int_index;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/free_list.sv ====
/*
 * Free physical tag queue with a tail, a speculative head and a
 * committed head; retired tags are pushed at the tail
 */
`timescale 1ns/1ps
`default_nettype none

module free_list
  import rename_cfg_pkg::*, micro_op_pkg::*;
(
  input  logic                              clock,
  input  logic                              rst_n,
  input  logic                              recover,
  input  logic                              fire,
  input  logic     [1:0]                    alloc_count,
  input  logic     [COMMIT_WIDTH-1:0]       retire_free_valid,
  input  prf_idx_t [COMMIT_WIDTH-1:0]       retire_free_tag,
  input  logic     [1:0]                    retire_alloc_count,
  output prf_idx_t [RENAME_WIDTH-1:0]       head_tags,
  output logic                              allocatable
);

  prf_idx_t fl_mem [PRF_INT_SIZE];

  fl_ptr_t  tail;
  fl_ptr_t  spec_head;
  fl_ptr_t  com_head;

  fl_ptr_t  tail_next;
  fl_ptr_t  push_ptr [COMMIT_WIDTH];
  fl_ptr_t  head_ptr [RENAME_WIDTH];
  fl_ptr_t  free_count;

  // Retired tags go in slot order, skipping slots with nothing to free
  always_comb begin
    tail_next = tail;
    for (int i = 0; i < COMMIT_WIDTH; i++) begin
      push_ptr[i] = tail_next;
      if (retire_free_valid[i]) begin
        tail_next = tail_next + fl_ptr_t'(1);
      end
    end
  end

  // Candidate tags for the next group, one per lane offset
  always_comb begin
    for (int k = 0; k < RENAME_WIDTH; k++) begin
      head_ptr[k]  = spec_head + fl_ptr_t'(k);
      head_tags[k] = fl_mem[head_ptr[k][PRF_IDX_W-1:0]];
    end
  end

  assign free_count  = tail - spec_head;
  assign allocatable = free_count >= fl_ptr_t'(RENAME_WIDTH);

  // Out of reset the queue holds every tag not used by the identity map
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < PRF_INT_SIZE; i++) begin
        fl_mem[i] <= prf_idx_t'(i + ARF_INT_SIZE);
      end
    end else begin
      for (int i = 0; i < COMMIT_WIDTH; i++) begin
        if (retire_free_valid[i]) begin
          fl_mem[push_ptr[i][PRF_IDX_W-1:0]] <= retire_free_tag[i];
        end
      end
    end
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      tail      <= fl_ptr_t'(PRF_INT_SIZE - ARF_INT_SIZE);
      spec_head <= '0;
      com_head  <= '0;
    end else begin
      tail     <= tail_next;
      com_head <= com_head + fl_ptr_t'(retire_alloc_count);
      if (recover) begin
        spec_head <= com_head;
      end else if (fire) begin
        spec_head <= spec_head + fl_ptr_t'(alloc_count);
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/rename_lane_if.sv ====
/*
 * Per-lane rename bundle: incoming micro-op, map lookups,
 * allocated tag and the renamed micro-op
 */
`timescale 1ns/1ps
`default_nettype none

interface rename_lane_if
  import rename_cfg_pkg::*, micro_op_pkg::*;
();

  micro_op_t uop;

  // Lookup indexes, zero for an invalid lane
  arf_idx_t  rs1;
  arf_idx_t  rs2;
  arf_idx_t  rd;
  logic      writes;

  // Speculative map results
  prf_idx_t  prs1;
  prf_idx_t  prs2;
  prf_idx_t  prev_rd;

  prf_idx_t  new_prd;
  micro_op_t uop_renamed;

  modport lane (
    output rs1, rs2, rd, writes, new_prd, uop_renamed,
    input  prs1, prs2, prev_rd
  );

  modport map (
    input  rs1, rs2, rd, writes, new_prd,
    output prs1, prs2, prev_rd
  );

  modport collect (
    input  uop_renamed, writes, rd, new_prd
  );

endinterface

`default_nettype wire

// ==== src/micro_op_pkg.sv ====
/*
 * Micro-op record seen by the rename stage, on the rename input,
 * the renamed output and the retire port
 */
`default_nettype none

package micro_op_pkg;

  import rename_cfg_pkg::*;

  typedef struct packed {
    logic     valid;
    // Set when the micro-op writes a register other than x0
    logic     rd_valid;

    // Architectural operands
    arf_idx_t rs1_arf_int_index;
    arf_idx_t rs2_arf_int_index;
    arf_idx_t rd_arf_int_index;

    // Physical tags filled in by rename
    prf_idx_t rs1_prf_int_index;
    prf_idx_t rs2_prf_int_index;
    prf_idx_t rd_prf_int_index;

    // Mapping displaced by rd, freed when this micro-op retires
    prf_idx_t rd_prf_int_index_prev;
    logic     rd_prf_int_index_prev_valid;

    logic [31:0] pc;
  } micro_op_t;

endpackage

`default_nettype wire

// ==== src/rename_cfg_pkg.sv ====
/*
 * Rename stage sizing: group widths, register file sizes,
 * and the index types for architectural, physical and free-list slots
 */
`default_nettype none

package rename_cfg_pkg;

  // Micro-ops handled per cycle
  localparam int RENAME_WIDTH = 2;
  localparam int COMMIT_WIDTH = 2;

  // Integer register files
  localparam int ARF_INT_SIZE = 32;
  localparam int PRF_INT_SIZE = 64;

  localparam int ARF_IDX_W = $clog2(ARF_INT_SIZE);
  localparam int PRF_IDX_W = $clog2(PRF_INT_SIZE);

  typedef logic [ARF_IDX_W-1:0] arf_idx_t;
  typedef logic [PRF_IDX_W-1:0] prf_idx_t;

  // Free-list pointer, one extra wrap bit above the slot address
  typedef logic [PRF_IDX_W:0] fl_ptr_t;

endpackage

`default_nettype wire
